// ==== logic/isa_pkg.sv ====
// rv32i encodings for the kept subset only (alu, lui, sw, beq, bne); other codes are not listed
package isa_pkg;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_RTYPE  = 7'b0110011; // register-register alu
    localparam logic [6:0] OP_ITYPE  = 7'b0010011; // register-immediate alu
    localparam logic [6:0] OP_LUI    = 7'b0110111; // load upper immediate
    localparam logic [6:0] OP_STORE  = 7'b0100011; // stores, only sw is executed
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // conditional branches

    // funct3 codes for the alu group
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl or sra, picked by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 codes for branches and stores
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010; // word store

    // field positions inside the instruction word
    localparam int RD_LSB  = 7;  // rd is inst[11:7]
    localparam int F3_LSB  = 12; // funct3 is inst[14:12]
    localparam int RS1_LSB = 15; // rs1 is inst[19:15]
    localparam int RS2_LSB = 20; // rs2 is inst[24:20]
    localparam int F7_ALT  = 30; // funct7 bit that turns add into sub and srl into sra

endpackage

// ==== logic/core_pkg.sv ====
// core types and constants; reset pc is fixed at zero and every word is 32 bits
package core_pkg;

    typedef logic [31:0] word_t;    // data word
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [4:0]  reg_idx_t; // x0..x31
    typedef logic [31:0] inst_t;    // raw instruction

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,    // also the branch compare
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui, operand b straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH_REQ,  // strobe low, waiting for the hold register to drain
        FETCH_WAIT, // strobe high, response expected
        FETCH_DROP  // strobe high, response will be thrown away after a redirect
    } fetch_state_t;

    localparam addr_t PC_RESET = 32'h0000_0000;
    localparam inst_t NOP_INST = 32'h0000_0013; // addi x0,x0,0

endpackage

// ==== logic/fetch_stage.sv ====
// one request in flight at most; a response that arrives while decode stalls goes to a one-entry hold
module fetch_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  core_pkg::inst_t      i_inst,
    input  logic                 i_ack_inst,
    output core_pkg::addr_t      o_iaddr,
    output logic                 o_stb_inst,
    input  logic                 i_d_ready,
    input  logic                 i_redirect,
    input  core_pkg::addr_t      i_target,
    output logic                 o_valid,
    output core_pkg::inst_t      o_inst,
    output core_pkg::addr_t      o_pc
);

    core_pkg::fetch_state_t state_q;
    core_pkg::addr_t iaddr_q;  // address on the bus
    core_pkg::addr_t tgt_q;    // redirect target parked during drop
    core_pkg::inst_t hold_inst_q;
    core_pkg::addr_t hold_pc_q;
    logic            hold_v_q;
    logic            resp;     // good response this cycle
    logic            out_free; // output slot empties or is empty
    logic            hold_v_next;

    assign resp        = (state_q == core_pkg::FETCH_WAIT) && i_ack_inst && !i_redirect;
    assign out_free    = !o_valid || i_d_ready;
    assign hold_v_next = (resp && !out_free) || (hold_v_q && !out_free);
    assign o_stb_inst  = (state_q != core_pkg::FETCH_REQ);
    assign o_iaddr     = iaddr_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= core_pkg::FETCH_REQ; // strobe low in reset, PC_RESET goes out next
            iaddr_q  <= core_pkg::PC_RESET;
            tgt_q    <= core_pkg::PC_RESET;
            o_valid  <= 1'b0;
            hold_v_q <= 1'b0;
        end else if (i_redirect) begin
            o_valid  <= 1'b0; // younger instructions are dead
            hold_v_q <= 1'b0;
            if (state_q != core_pkg::FETCH_REQ && !i_ack_inst) begin
                state_q <= core_pkg::FETCH_DROP; // keep old address until its ack
                tgt_q   <= i_target;
            end else begin
                state_q <= core_pkg::FETCH_WAIT;
                iaddr_q <= i_target;
            end
        end else begin
            if (out_free) o_valid <= hold_v_q || resp;
            hold_v_q <= hold_v_next;
            case (state_q)
                core_pkg::FETCH_WAIT: if (i_ack_inst) begin
                    iaddr_q <= iaddr_q + 32'd4;
                    if (hold_v_next) state_q <= core_pkg::FETCH_REQ; // no room for another
                end
                core_pkg::FETCH_REQ: if (!hold_v_next) state_q <= core_pkg::FETCH_WAIT;
                core_pkg::FETCH_DROP: if (i_ack_inst) begin
                    iaddr_q <= tgt_q; // stale word discarded here
                    state_q <= core_pkg::FETCH_WAIT;
                end
                default: state_q <= core_pkg::FETCH_WAIT;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_free) begin
            o_inst <= hold_v_q ? hold_inst_q : i_inst; // older word first
            o_pc   <= hold_v_q ? hold_pc_q : iaddr_q;
        end
        if (resp && !out_free) begin
            hold_inst_q <= i_inst;
            hold_pc_q   <= iaddr_q;
        end
    end

endmodule

// ==== logic/regfile.sv ====
// two async read ports, one write port; a same-cycle write is seen by the reads
module regfile (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  core_pkg::reg_idx_t   i_rs1,
    input  core_pkg::reg_idx_t   i_rs2,
    output core_pkg::word_t      o_rs1_val,
    output core_pkg::word_t      o_rs2_val,
    input  logic                 i_wr_en,
    input  core_pkg::reg_idx_t   i_wr_idx,
    input  core_pkg::word_t      i_wr_data
);

    core_pkg::word_t regs_q [1:31]; // x0 has no storage
    logic            wr_live;

    assign wr_live = i_wr_en && (i_wr_idx != 5'd0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0; // known contents for the first reads
            end
        end else if (wr_live) begin
            regs_q[i_wr_idx] <= i_wr_data;
        end
    end

    // bypass replaces a forwarding unit, execute writes in the cycle decode reads
    assign o_rs1_val = (i_rs1 == 5'd0) ? '0 :
                       (wr_live && i_wr_idx == i_rs1) ? i_wr_data : regs_q[i_rs1];
    assign o_rs2_val = (i_rs2 == 5'd0) ? '0 :
                       (wr_live && i_wr_idx == i_rs2) ? i_wr_data : regs_q[i_rs2];

endmodule

// ==== logic/decode_stage.sv ====
// unknown opcodes, byte and halfword stores and other branch kinds decode as addi x0,x0,0
module decode_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  core_pkg::inst_t      i_inst,
    input  core_pkg::addr_t      i_pc,
    output logic                 o_ready,
    input  logic                 i_busy,
    input  logic                 i_flush,
    output core_pkg::reg_idx_t   o_rs1,
    output core_pkg::reg_idx_t   o_rs2,
    input  core_pkg::word_t      i_rs1_val,
    input  core_pkg::word_t      i_rs2_val,
    output logic                 o_valid,
    output logic [6:0]           o_op,
    output core_pkg::alu_op_t    o_alu_op,
    output logic [2:0]           o_funct3,
    output core_pkg::word_t      o_imm,
    output core_pkg::word_t      o_rs1_val,
    output core_pkg::word_t      o_rs2_val,
    output core_pkg::reg_idx_t   o_rd,
    output core_pkg::addr_t      o_pc
);

    core_pkg::inst_t   inst; // instruction actually decoded
    core_pkg::word_t   imm;
    core_pkg::alu_op_t alu_op;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt;
    logic              known;

    always_comb begin
        case (i_inst[6:0])
            isa_pkg::OP_RTYPE, isa_pkg::OP_ITYPE, isa_pkg::OP_LUI: known = 1'b1;
            isa_pkg::OP_STORE: known = (i_inst[isa_pkg::F3_LSB +: 3] == isa_pkg::F3_SW);
            isa_pkg::OP_BRANCH: known = (i_inst[isa_pkg::F3_LSB +: 3] == isa_pkg::F3_BEQ) ||
                                        (i_inst[isa_pkg::F3_LSB +: 3] == isa_pkg::F3_BNE);
            default: known = 1'b0;
        endcase
    end

    assign inst    = (i_valid && known && !i_flush) ? i_inst : core_pkg::NOP_INST;
    assign opcode  = inst[6:0];
    assign funct3  = inst[isa_pkg::F3_LSB +: 3];
    assign alt     = inst[isa_pkg::F7_ALT];
    assign o_rs1   = inst[isa_pkg::RS1_LSB +: 5]; // nop reads x0
    assign o_rs2   = inst[isa_pkg::RS2_LSB +: 5];
    assign o_ready = !i_busy; // execute drains every cycle except a waiting store

    always_comb begin
        case (opcode)
            isa_pkg::OP_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            isa_pkg::OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                       inst[11:8], 1'b0};
            isa_pkg::OP_LUI:    imm = {inst[31:12], 12'b0};
            default:            imm = {{20{inst[31]}}, inst[31:20]}; // i-type and shamt
        endcase
    end

    always_comb begin
        alu_op = core_pkg::ALU_ADD; // store address is rs1 + offset
        case (opcode)
            isa_pkg::OP_LUI:    alu_op = core_pkg::ALU_PASS_B;
            isa_pkg::OP_BRANCH: alu_op = core_pkg::ALU_SUB; // zero result means equal
            isa_pkg::OP_RTYPE, isa_pkg::OP_ITYPE: begin
                case (funct3)
                    isa_pkg::F3_ADD: alu_op = (alt && opcode == isa_pkg::OP_RTYPE) ?
                                              core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    isa_pkg::F3_SLL:  alu_op = core_pkg::ALU_SLL;
                    isa_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
                    isa_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
                    isa_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
                    isa_pkg::F3_SR:   alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                    isa_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
                    default:          alu_op = core_pkg::ALU_AND;
                endcase
            end
            default: alu_op = core_pkg::ALU_ADD;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush || !i_busy) begin
            o_valid <= i_valid && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_flush || !i_busy) begin // held while a store waits
            o_op      <= opcode;
            o_alu_op  <= alu_op;
            o_funct3  <= funct3;
            o_imm     <= imm;
            o_rs1_val <= i_rs1_val;
            o_rs2_val <= i_rs2_val;
            o_rd      <= inst[isa_pkg::RD_LSB +: 5];
            o_pc      <= i_pc;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
// alu results and register writes retire the cycle they arrive; only sw reaches the data port
module execute_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  logic [6:0]           i_op,
    input  core_pkg::alu_op_t    i_alu_op,
    input  logic [2:0]           i_funct3,
    input  core_pkg::word_t      i_imm,
    input  core_pkg::word_t      i_rs1_val,
    input  core_pkg::word_t      i_rs2_val,
    input  core_pkg::reg_idx_t   i_rd,
    input  core_pkg::addr_t      i_pc,
    output logic                 o_busy,
    output logic                 o_redirect,
    output core_pkg::addr_t      o_target,
    output logic                 o_wr_en,
    output core_pkg::reg_idx_t   o_wr_idx,
    output core_pkg::word_t      o_wr_data,
    output core_pkg::addr_t      o_daddr,
    output core_pkg::word_t      o_dout,
    output logic                 o_stb_data,
    input  logic                 i_ack_data
);

    core_pkg::word_t op_b;
    core_pkg::word_t alu_y;
    core_pkg::addr_t st_addr_q; // store captured on its first strobe cycle
    core_pkg::word_t st_data_q;
    logic            st_pend_q; // strobe already up, ack still missing
    logic            is_store;

    assign op_b = (i_op == isa_pkg::OP_RTYPE || i_op == isa_pkg::OP_BRANCH) ? i_rs2_val : i_imm;

    always_comb begin
        case (i_alu_op)
            core_pkg::ALU_SUB:    alu_y = i_rs1_val - op_b;
            core_pkg::ALU_SLL:    alu_y = i_rs1_val << op_b[4:0];
            core_pkg::ALU_SLT:    alu_y = {31'b0, $signed(i_rs1_val) < $signed(op_b)};
            core_pkg::ALU_SLTU:   alu_y = {31'b0, i_rs1_val < op_b};
            core_pkg::ALU_XOR:    alu_y = i_rs1_val ^ op_b;
            core_pkg::ALU_SRL:    alu_y = i_rs1_val >> op_b[4:0];
            core_pkg::ALU_SRA:    alu_y = $signed(i_rs1_val) >>> op_b[4:0];
            core_pkg::ALU_OR:     alu_y = i_rs1_val | op_b;
            core_pkg::ALU_AND:    alu_y = i_rs1_val & op_b;
            core_pkg::ALU_PASS_B: alu_y = op_b; // lui
            default:              alu_y = i_rs1_val + op_b;
        endcase
    end

    // branch, decode only lets beq and bne through
    assign o_redirect = i_valid && (i_op == isa_pkg::OP_BRANCH) &&
                        ((alu_y == '0) == (i_funct3 == isa_pkg::F3_BEQ));
    assign o_target   = i_pc + i_imm;

    // register write, x0 filtered in the regfile
    assign o_wr_en   = i_valid && (i_op == isa_pkg::OP_RTYPE || i_op == isa_pkg::OP_ITYPE ||
                                   i_op == isa_pkg::OP_LUI);
    assign o_wr_idx  = i_rd;
    assign o_wr_data = alu_y;

    // store strobe, up from the first cycle until the ack cycle
    assign is_store   = i_valid && (i_op == isa_pkg::OP_STORE);
    assign o_stb_data = is_store;
    assign o_busy     = is_store && !i_ack_data; // freezes decode
    assign o_daddr    = st_pend_q ? st_addr_q : alu_y;
    assign o_dout     = st_pend_q ? st_data_q : i_rs2_val;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st_pend_q <= 1'b0;
        end else begin
            st_pend_q <= o_busy;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!st_pend_q) begin
            st_addr_q <= alu_y;
            st_data_q <= i_rs2_val;
        end
    end

endmodule

// ==== logic/rv32i_core.sv ====
// three-stage rv32i subset core; no loads, no csr, no interrupts, stores are always full words
module rv32i_core (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  core_pkg::inst_t      i_inst,
    input  logic                 i_ack_inst,
    output core_pkg::addr_t      o_iaddr,
    output logic                 o_stb_inst,
    output core_pkg::addr_t      o_daddr,
    output core_pkg::word_t      o_dout,
    output logic                 o_stb_data,
    input  logic                 i_ack_data
);

    logic               f_valid;
    core_pkg::inst_t    f_inst;
    core_pkg::addr_t    f_pc;
    logic               d_ready;
    logic               d_valid;
    logic [6:0]         d_op;
    core_pkg::alu_op_t  d_alu_op;
    logic [2:0]         d_funct3;
    core_pkg::word_t    d_imm;
    core_pkg::word_t    d_rs1_val;
    core_pkg::word_t    d_rs2_val;
    core_pkg::reg_idx_t d_rd;
    core_pkg::addr_t    d_pc;
    core_pkg::reg_idx_t rs1_idx;
    core_pkg::reg_idx_t rs2_idx;
    core_pkg::word_t    rf_rs1_val;
    core_pkg::word_t    rf_rs2_val;
    logic               x_busy;
    logic               x_redirect;
    core_pkg::addr_t    x_target;
    logic               x_wr_en;
    core_pkg::reg_idx_t x_wr_idx;
    core_pkg::word_t    x_wr_data;

    fetch_stage u_fetch (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_inst(i_inst), .i_ack_inst(i_ack_inst),
        .o_iaddr(o_iaddr), .o_stb_inst(o_stb_inst),
        .i_d_ready(d_ready),
        .i_redirect(x_redirect), .i_target(x_target),
        .o_valid(f_valid), .o_inst(f_inst), .o_pc(f_pc)
    );

    regfile u_regfile (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rs1(rs1_idx), .i_rs2(rs2_idx),
        .o_rs1_val(rf_rs1_val), .o_rs2_val(rf_rs2_val),
        .i_wr_en(x_wr_en), .i_wr_idx(x_wr_idx), .i_wr_data(x_wr_data)
    );

    decode_stage u_decode (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_valid(f_valid), .i_inst(f_inst), .i_pc(f_pc),
        .o_ready(d_ready), .i_busy(x_busy), .i_flush(x_redirect),
        .o_rs1(rs1_idx), .o_rs2(rs2_idx),
        .i_rs1_val(rf_rs1_val), .i_rs2_val(rf_rs2_val),
        .o_valid(d_valid), .o_op(d_op), .o_alu_op(d_alu_op), .o_funct3(d_funct3),
        .o_imm(d_imm), .o_rs1_val(d_rs1_val), .o_rs2_val(d_rs2_val),
        .o_rd(d_rd), .o_pc(d_pc)
    );

    execute_stage u_execute (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_valid(d_valid), .i_op(d_op), .i_alu_op(d_alu_op), .i_funct3(d_funct3),
        .i_imm(d_imm), .i_rs1_val(d_rs1_val), .i_rs2_val(d_rs2_val),
        .i_rd(d_rd), .i_pc(d_pc),
        .o_busy(x_busy), .o_redirect(x_redirect), .o_target(x_target),
        .o_wr_en(x_wr_en), .o_wr_idx(x_wr_idx), .o_wr_data(x_wr_data),
        .o_daddr(o_daddr), .o_dout(o_dout), .o_stb_data(o_stb_data),
        .i_ack_data(i_ack_data)
    );

endmodule

// ==== testbench/core_sva.sv ====
// handshake checks on the core ports; hold rules assume one outstanding request, off in reset
module core_sva (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [31:0] o_iaddr,
    input  logic        o_stb_inst,
    input  logic        i_ack_inst,
    input  logic [31:0] o_daddr,
    input  logic [31:0] o_dout,
    input  logic        o_stb_data,
    input  logic        i_ack_data
);

    // fetch address may only move on an ack
    a_iaddr_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_stb_inst && !i_ack_inst) |=> (o_stb_inst && $stable(o_iaddr)))
        else $error("instruction strobe dropped or address moved before its ack");

    // store address and data frozen until the ack
    a_store_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_stb_data && !i_ack_data) |=> (o_stb_data && $stable(o_daddr) && $stable(o_dout)))
        else $error("data strobe dropped or store changed before its ack");

    a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> (!o_stb_inst && !o_stb_data))
        else $error("memory strobe high during reset");

endmodule

bind rv32i_core core_sva u_sva (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .o_iaddr(o_iaddr),
    .o_stb_inst(o_stb_inst),
    .i_ack_inst(i_ack_inst),
    .o_daddr(o_daddr),
    .o_dout(o_dout),
    .o_stb_data(o_stb_data),
    .i_ack_data(i_ack_data)
);

// ==== testbench/core_tb.sv ====
// directed tests; each program fits in 256 words and must end in beq x0,x0,0 as its end marker
module core_tb;

    logic               clk;
    logic               rst_n;
    core_pkg::inst_t    inst;
    logic               ack_inst;
    core_pkg::addr_t    iaddr;
    logic               stb_inst;
    core_pkg::addr_t    daddr;
    core_pkg::word_t    dout;
    logic               stb_data;
    logic               ack_data;

    core_pkg::inst_t    rom [0:255];
    core_pkg::word_t    model [0:31]; // architectural registers as the isa defines them
    core_pkg::addr_t    exp_addr [$];
    core_pkg::word_t    exp_data [$];
    core_pkg::addr_t    got_addr [$];
    core_pkg::word_t    got_data [$];
    logic [7:0]         pc_w;         // next rom slot to fill
    logic [11:0]        st_off;
    core_pkg::addr_t    end_pc;
    int                 end_acks;
    int                 errors;
    int                 seed;
    logic               fixed_ack;
    logic               in_reset;     // reset level seen at the last edge
    int                 icnt;
    int                 idelay;
    int                 dcnt;
    int                 ddelay;

    rv32i_core dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_inst(inst), .i_ack_inst(ack_inst),
        .o_iaddr(iaddr), .o_stb_inst(stb_inst),
        .o_daddr(daddr), .o_dout(dout), .o_stb_data(stb_data),
        .i_ack_data(ack_data)
    );

    always #10 clk = ~clk;

    function automatic int pick_delay(int max);
        if (fixed_ack) return 1;
        return 1 + int'({$random(seed)} % max);
    endfunction

    // memory models, acks and read data driven 2 units after the edge
    always @(posedge clk) begin
        in_reset = !rst_n; // taken at the edge, before the stimulus moves
        #2;
        ack_inst = 1'b0;
        ack_data = 1'b0;
        if (in_reset) begin
            icnt     = 0;
            dcnt     = 0;
            end_acks = 0;
        end else begin
            if (stb_inst) begin
                icnt++;
                if (icnt >= idelay) begin
                    ack_inst = 1'b1;
                    inst     = rom[iaddr[9:2]];
                    if (iaddr == end_pc) end_acks++; // second hit means the end branch ran
                    icnt     = 0;
                    idelay   = pick_delay(3);
                end
            end
            if (stb_data) begin
                dcnt++;
                if (dcnt >= ddelay) begin
                    ack_data = 1'b1;
                    got_addr.push_back(daddr); // one entry per completed store
                    got_data.push_back(dout);
                    dcnt     = 0;
                    ddelay   = pick_delay(4);
                end
            end
        end
    end

    function automatic core_pkg::word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // reference results straight from the rv32i definitions
    function automatic core_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                                core_pkg::word_t a, core_pkg::word_t b);
        core_pkg::word_t r;
        case (f3)
            isa_pkg::F3_ADD:  r = alt ? a - b : a + b;
            isa_pkg::F3_SLL:  r = a << b[4:0];
            isa_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            isa_pkg::F3_XOR:  r = a ^ b;
            isa_pkg::F3_SR:   r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            isa_pkg::F3_OR:   r = a | b;
            default:          r = a & b;
        endcase
        return r;
    endfunction

    function automatic core_pkg::inst_t enc_r(logic [2:0] f3, logic alt, logic [4:0] rd,
                                              logic [4:0] rs1, logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, isa_pkg::OP_RTYPE};
    endfunction

    function automatic core_pkg::inst_t enc_i(logic [2:0] f3, logic [4:0] rd,
                                              logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, isa_pkg::OP_ITYPE};
    endfunction

    function automatic core_pkg::inst_t enc_s(logic [4:0] rs2, logic [4:0] rs1,
                                              logic [11:0] off);
        return {off[11:5], rs2, rs1, isa_pkg::F3_SW, off[4:0], isa_pkg::OP_STORE};
    endfunction

    function automatic core_pkg::inst_t enc_b(logic [2:0] f3, logic [4:0] rs1,
                                              logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isa_pkg::OP_BRANCH};
    endfunction

    task automatic put(core_pkg::inst_t w);
        rom[pc_w] = w;
        pc_w      = pc_w + 8'd1;
    endtask

    task automatic op_r(logic [2:0] f3, logic alt, logic [4:0] rd,
                        logic [4:0] rs1, logic [4:0] rs2);
        put(enc_r(f3, alt, rd, rs1, rs2));
        if (rd != 5'd0) model[rd] = alu_ref(f3, alt, model[rs1], model[rs2]);
    endtask

    task automatic op_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        logic alt;
        alt = (f3 == isa_pkg::F3_SR) && imm[10]; // srai
        put(enc_i(f3, rd, rs1, imm));
        if (rd != 5'd0) model[rd] = alu_ref(f3, alt, model[rs1], sext12(imm));
    endtask

    task automatic op_lui(logic [4:0] rd, logic [19:0] imm);
        put({imm, rd, isa_pkg::OP_LUI});
        if (rd != 5'd0) model[rd] = {imm, 12'b0};
    endtask

    task automatic store_next(logic [4:0] rs2);
        put(enc_s(rs2, 5'd0, st_off));
        exp_addr.push_back(sext12(st_off));
        exp_data.push_back(model[rs2]);
        st_off = st_off + 12'd4;
    endtask

    task automatic load_const(logic [4:0] rd, core_pkg::word_t val);
        core_pkg::word_t t;
        t = val + 32'h800; // addi sign-extends its low part
        op_lui(rd, t[31:12]);
        op_i(isa_pkg::F3_ADD, rd, rd, val[11:0]);
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) rom[i[7:0]] = core_pkg::NOP_INST;
        for (int i = 0; i < 32; i++) model[i[4:0]] = '0;
        exp_addr.delete();
        exp_data.delete();
        pc_w   = 8'd0;
        st_off = 12'h100;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic run_program(string name);
        int cycles;
        put(enc_b(isa_pkg::F3_BEQ, 5'd0, 5'd0, 13'd0)); // spin here at the end
        end_pc = {22'b0, pc_w - 8'd1, 2'b00};
        got_addr.delete();
        got_data.delete();
        apply_reset();
        cycles = 0;
        while (end_acks < 2 && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        if (end_acks < 2) begin
            errors++;
            $display("%s: timed out before reaching the final branch", name);
        end
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("ERROR %s store count expected %h got %h", name,
                     exp_addr.size(), got_addr.size());
        end
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            if (got_addr[i] !== exp_addr[i]) begin
                errors++;
                $display("ERROR %s o_daddr store %0d expected %h got %h", name, i,
                         exp_addr[i], got_addr[i]);
            end
            if (got_data[i] !== exp_data[i]) begin
                errors++;
                $display("ERROR %s o_dout store %0d expected %h got %h", name, i,
                         exp_data[i], got_data[i]);
            end
        end
    endtask

    task automatic test_reset();
        int cycles;
        new_program();
        put(core_pkg::NOP_INST);
        end_pc = 32'h0000_0004;
        apply_reset();
        @(negedge clk); // first cycle out of reset
        if (stb_data !== 1'b0) begin
            errors++;
            $display("ERROR o_stb_data expected %h got %h", 1'b0, stb_data);
        end
        cycles = 0;
        while (stb_inst !== 1'b1 && cycles < 20) begin // wait for the first fetch
            @(negedge clk);
            cycles++;
        end
        if (stb_inst !== 1'b1) begin
            errors++;
            $display("instruction strobe never rose after reset");
        end else if (iaddr !== core_pkg::PC_RESET) begin
            errors++;
            $display("ERROR o_iaddr expected %h got %h", core_pkg::PC_RESET, iaddr);
        end
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        new_program();
        load_const(5'd1, $random(seed));
        load_const(5'd2, $random(seed));
        for (int k = 0; k < 8; k++) begin
            op_r(3'(k), 1'b0, 5'd3, 5'd1, 5'd2);
            store_next(5'd3);
        end
        op_r(isa_pkg::F3_ADD, 1'b1, 5'd3, 5'd1, 5'd2); // sub
        store_next(5'd3);
        op_r(isa_pkg::F3_SR, 1'b1, 5'd3, 5'd1, 5'd2);  // sra
        store_next(5'd3);
        for (int k = 0; k < 8; k++) begin
            imm = 12'($random(seed));
            if (k == 1 || k == 5) imm = {7'b0, imm[4:0]}; // slli, srli
            op_i(3'(k), 5'd4, 5'd1, imm);
            store_next(5'd4);
        end
        op_i(isa_pkg::F3_SR, 5'd4, 5'd1, {7'b0100000, 5'($random(seed))}); // srai
        store_next(5'd4);
        run_program("alu");
    endtask

    task automatic build_chain();
        new_program();
        load_const(5'd1, 32'h8765_4321);
        op_i(isa_pkg::F3_ADD, 5'd2, 5'd1, 12'h7ff);
        op_r(isa_pkg::F3_ADD, 1'b0, 5'd3, 5'd2, 5'd1);
        store_next(5'd3);
        op_r(isa_pkg::F3_XOR, 1'b0, 5'd4, 5'd3, 5'd2);
        op_i(isa_pkg::F3_SLL, 5'd5, 5'd4, 12'd5);
        op_r(isa_pkg::F3_ADD, 1'b1, 5'd6, 5'd5, 5'd1);
        store_next(5'd6);
        store_next(5'd5);
        for (int k = 0; k < 4; k++) begin
            op_r(isa_pkg::F3_ADD, 1'b0, 5'd6, 5'd6, 5'd6); // doubles each time
            store_next(5'd6);
        end
    endtask

    task automatic test_chain();
        build_chain();
        run_program("chain");
    endtask

    task automatic test_branch();
        new_program();
        op_i(isa_pkg::F3_ADD, 5'd1, 5'd0, 12'd7);
        op_i(isa_pkg::F3_ADD, 5'd2, 5'd0, 12'd7);
        op_i(isa_pkg::F3_ADD, 5'd3, 5'd0, 12'd9);
        put(enc_b(isa_pkg::F3_BEQ, 5'd1, 5'd2, 13'd12)); // taken, skips two stores
        put(enc_s(5'd1, 5'd0, 12'h200));
        put(enc_s(5'd2, 5'd0, 12'h204));
        store_next(5'd3);
        put(enc_b(isa_pkg::F3_BNE, 5'd1, 5'd3, 13'd8));  // taken
        put(enc_s(5'd3, 5'd0, 12'h208));
        store_next(5'd1);
        put(enc_b(isa_pkg::F3_BEQ, 5'd1, 5'd3, 13'd8));  // not taken
        store_next(5'd2);
        put(enc_b(isa_pkg::F3_BNE, 5'd1, 5'd2, 13'd8));  // not taken
        store_next(5'd3);
        op_i(isa_pkg::F3_ADD, 5'd4, 5'd0, 12'd1);
        put(enc_b(isa_pkg::F3_BNE, 5'd4, 5'd0, 13'd8));  // compares a bypassed value
        put(enc_s(5'd4, 5'd0, 12'h20c));
        store_next(5'd4);
        run_program("branch");
    endtask

    task automatic test_ack_delays();
        fixed_ack = 1'b1;
        idelay    = 1;
        ddelay    = 1;
        build_chain();
        run_program("min_ack");
        fixed_ack = 1'b0;
        build_chain();
        run_program("random_ack");
    endtask

    task automatic test_x0();
        new_program();
        op_i(isa_pkg::F3_ADD, 5'd1, 5'd0, 12'd5);
        op_i(isa_pkg::F3_ADD, 5'd0, 5'd0, 12'h07b);   // dropped
        op_lui(5'd0, 20'habcde);
        op_r(isa_pkg::F3_ADD, 1'b0, 5'd0, 5'd1, 5'd1);
        store_next(5'd0);
        op_r(isa_pkg::F3_ADD, 1'b0, 5'd5, 5'd0, 5'd0);
        store_next(5'd5);
        op_r(isa_pkg::F3_OR, 1'b0, 5'd6, 5'd0, 5'd1);
        store_next(5'd6);
        run_program("x0");
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst      = core_pkg::NOP_INST;
        ack_inst  = 1'b0;
        ack_data  = 1'b0;
        errors    = 0;
        seed      = 85;
        fixed_ack = 1'b0;
        end_pc    = '1;
        idelay    = pick_delay(3);
        ddelay    = pick_delay(4);
        test_reset();
        test_alu();
        test_chain();
        test_branch();
        test_ack_delays();
        test_x0();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/fetch_stage.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv32i_core.sv
testbench/core_sva.sv
testbench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module core_tb -o core_sim
./obj_dir/core_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi
